// File: hw/cnn_pkg.sv
package cnn_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int DATA_W      = 32;
    localparam int MAX_TAPS    = 4;
    localparam int TAP_IDX_W   = 3;                 // Holds 1..MAX_TAPS.
    localparam int LEN_W       = 12;
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_IDX_W  = $clog2(FIFO_DEPTH);
    localparam int MAC_LATENCY = 2;

    // Tap 0 holds the oldest input word.
    typedef logic [MAX_TAPS-1:0][DATA_W-1:0] window_t;
    typedef logic [MAX_TAPS-1:0][DATA_W-1:0] weights_t;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [1:0] {
        OP_CONF_SRC = 2'd0,                         // rj src, rk N and K.
        OP_CONF_DST = 2'd1,                         // rj dst.
        OP_CONV     = 2'd2,                         // imm[0] loads weights.
        OP_NOP      = 2'd3
    } opcode_e;

    typedef enum logic [1:0] {
        RUN_IDLE   = 2'd0,
        RUN_WEIGHT = 2'd1,
        RUN_CONV   = 2'd2
    } run_state_e;

endpackage

// File: hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    input  cnn_pkg::opcode_e              req_op_i,
    input  logic                          req_imm_i,
    input  logic [cnn_pkg::DATA_W-1:0]    req_rj_i,
    input  logic [cnn_pkg::DATA_W-1:0]    req_rk_i,
    input  logic                          fetch_done_i,
    input  logic                          write_done_i,
    output logic                          req_ready_o,
    output logic                          rsp_valid_o,
    output logic                          start_weight_o,
    output logic                          start_conv_o,
    output logic [cnn_pkg::DATA_W-1:0]    src_addr_o,
    output logic [cnn_pkg::DATA_W-1:0]    weight_addr_o,
    output logic [cnn_pkg::DATA_W-1:0]    dst_addr_o,
    output logic [cnn_pkg::LEN_W-1:0]     length_o,
    output logic [cnn_pkg::TAP_IDX_W-1:0] taps_o,
    output logic [cnn_pkg::LEN_W-1:0]     res_count_o
);
    import cnn_pkg::*;

    run_state_e           state_q;
    logic                 cmd_hsk;
    logic                 conv_hsk;
    logic [LEN_W-1:0]     new_len;
    logic [TAP_IDX_W-1:0] new_taps;

    assign req_ready_o = (state_q == RUN_IDLE);
    assign cmd_hsk     = req_valid_i & req_ready_o;
    assign conv_hsk    = cmd_hsk & (req_op_i == OP_CONV);
    assign new_len     = req_rk_i[LEN_W-1:0];
    assign new_taps    = req_rk_i[LEN_W +: TAP_IDX_W];      // rk[14:12].

    // ------------------------------
    // Configuration registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (cmd_hsk && req_op_i == OP_CONF_SRC) begin
            src_addr_o  <= req_rj_i;
            length_o    <= new_len;
            taps_o      <= new_taps;
            res_count_o <= new_len - LEN_W'(new_taps) + LEN_W'(1);  // N-K+1 outputs.
        end
        if (cmd_hsk && req_op_i == OP_CONF_DST) begin
            dst_addr_o <= req_rj_i;
        end
        if (conv_hsk) begin
            weight_addr_o <= req_rj_i;
        end
    end

    // ------------------------------
    // Run FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q        <= RUN_IDLE;
            start_weight_o <= 1'b0;
            start_conv_o   <= 1'b0;
            rsp_valid_o    <= 1'b0;
        end else begin
            start_weight_o <= conv_hsk & req_imm_i;
            start_conv_o   <= (conv_hsk & ~req_imm_i) | ((state_q == RUN_WEIGHT) & fetch_done_i);
            rsp_valid_o    <= (cmd_hsk & (req_op_i != OP_CONV)) |
                              ((state_q == RUN_CONV) & write_done_i);
            case (state_q)
                RUN_IDLE:   if (conv_hsk) state_q <= req_imm_i ? RUN_WEIGHT : RUN_CONV;
                RUN_WEIGHT: if (fetch_done_i) state_q <= RUN_CONV;
                RUN_CONV:   if (write_done_i) state_q <= RUN_IDLE;
                default:    state_q <= RUN_IDLE;
            endcase
        end
    end

    // Done pulses from the datapath only arrive during a run.
    a_done_in_run: assert property (@(posedge clk) disable iff (rst)
        (state_q == RUN_IDLE) |-> !fetch_done_i && !write_done_i);

endmodule

// File: hw/window_fetch.sv
`timescale 1ns/1ps

module window_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_weight_i,
    input  logic                          start_conv_i,
    input  logic [cnn_pkg::DATA_W-1:0]    src_addr_i,
    input  logic [cnn_pkg::DATA_W-1:0]    weight_addr_i,
    input  logic [cnn_pkg::LEN_W-1:0]     length_i,
    input  logic [cnn_pkg::TAP_IDX_W-1:0] taps_i,
    input  logic                          rd_ready_i,
    input  logic                          rsp_valid_i,
    input  logic [cnn_pkg::DATA_W-1:0]    rsp_rdata_i,
    input  logic                          space_ok_i,
    output logic                          rd_valid_o,
    output logic [cnn_pkg::DATA_W-1:0]    rd_addr_o,
    output logic                          fetch_done_o,
    output logic                          win_valid_o,
    output cnn_pkg::window_t              window_o,
    output cnn_pkg::weights_t             weights_o
);
    import cnn_pkg::*;

    run_state_e       phase_q;
    logic             pending_q;                // Read accepted, data not back.
    logic [LEN_W-1:0] req_cnt_q;
    logic [LEN_W-1:0] rsp_cnt_q;
    logic [LEN_W-1:0] total;
    logic             issue;
    logic             last_rsp;
    window_t          window_q;
    window_t          win_next;

    assign total    = (phase_q == RUN_WEIGHT) ? LEN_W'(taps_i) : length_i;
    assign last_rsp = rsp_valid_i & (rsp_cnt_q == total - LEN_W'(1));
    assign issue    = (phase_q != RUN_IDLE) & ~rd_valid_o & ~pending_q &
                      (req_cnt_q < total) & ((phase_q == RUN_WEIGHT) | space_ok_i);

    assign fetch_done_o = (phase_q != RUN_IDLE) & last_rsp;
    assign win_valid_o  = (phase_q == RUN_CONV) & rsp_valid_i &
                          (rsp_cnt_q >= LEN_W'(taps_i) - LEN_W'(1));
    assign window_o     = win_next;

    // New word lands at tap K-1, lower taps shift down.
    always_comb begin
        win_next = window_q;
        for (int t = 0; t < MAX_TAPS - 1; t++) begin
            if (t < int'(taps_i) - 1) win_next[t] = window_q[t + 1];
        end
        for (int t = 0; t < MAX_TAPS; t++) begin
            if (t == int'(taps_i) - 1) win_next[t] = rsp_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q    <= RUN_IDLE;
            rd_valid_o <= 1'b0;
            pending_q  <= 1'b0;
            req_cnt_q  <= '0;
            rsp_cnt_q  <= '0;
            rd_addr_o  <= '0;
        end else if (start_weight_i || start_conv_i) begin
            phase_q   <= start_weight_i ? RUN_WEIGHT : RUN_CONV;
            rd_addr_o <= start_weight_i ? weight_addr_i : src_addr_i;
            req_cnt_q <= '0;
            rsp_cnt_q <= '0;
        end else begin
            if (issue) rd_valid_o <= 1'b1;
            if (rd_valid_o && rd_ready_i) begin
                rd_valid_o <= 1'b0;
                pending_q  <= 1'b1;
                rd_addr_o  <= rd_addr_o + DATA_W'(4);   // Next word.
                req_cnt_q  <= req_cnt_q + LEN_W'(1);
            end
            if (rsp_valid_i) begin
                pending_q <= 1'b0;
                rsp_cnt_q <= rsp_cnt_q + LEN_W'(1);
            end
            if (fetch_done_o) phase_q <= RUN_IDLE;
        end
    end

    // Weight store and window shift register.
    always_ff @(posedge clk) begin
        if (start_weight_i) begin
            weights_o <= '0;                        // Unused taps stay zero.
        end else if (phase_q == RUN_WEIGHT && rsp_valid_i) begin
            for (int t = 0; t < MAX_TAPS; t++) begin
                if (rsp_cnt_q == LEN_W'(t)) weights_o[t] <= rsp_rdata_i;
            end
        end
        if (start_conv_i) begin
            window_q <= '0;
        end else if (phase_q == RUN_CONV && rsp_valid_i) begin
            window_q <= win_next;
        end
    end

    // Each response answers the one read still in flight.
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        rsp_valid_i |-> pending_q);

endmodule

// File: hw/conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       win_valid_i,
    input  cnn_pkg::window_t           window_i,
    input  cnn_pkg::weights_t          weights_i,
    output logic                       res_valid_o,
    output logic [cnn_pkg::DATA_W-1:0] res_data_o
);
    import cnn_pkg::*;

    logic [MAX_TAPS-1:0][DATA_W-1:0] prod_q;
    logic                            prod_valid_q;
    logic [DATA_W-1:0]               sum;

    always_comb begin
        sum = '0;
        for (int t = 0; t < MAX_TAPS; t++) begin
            sum = sum + prod_q[t];                  // Wraps mod 2^32.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid_q <= 1'b0;
            res_valid_o  <= 1'b0;
        end else begin
            prod_valid_q <= win_valid_i;
            res_valid_o  <= prod_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 0; t < MAX_TAPS; t++) begin
            prod_q[t] <= window_i[t] * weights_i[t];    // Low 32 bits kept.
        end
        res_data_o <= sum;
    end

endmodule

// File: hw/result_fifo.sv
`timescale 1ns/1ps

module result_fifo (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push_i,
    input  logic [cnn_pkg::DATA_W-1:0] push_data_i,
    input  logic                       pop_i,
    output logic                       valid_o,
    output logic [cnn_pkg::DATA_W-1:0] data_o,
    output logic                       space_ok_o
);
    import cnn_pkg::*;

    logic [DATA_W-1:0]     mem_q [FIFO_DEPTH];
    logic [FIFO_IDX_W-1:0] head_q;
    logic [FIFO_IDX_W-1:0] tail_q;
    logic                  head_wrap_q;
    logic                  tail_wrap_q;
    logic [FIFO_IDX_W:0]   used;
    logic                  full;

    assign used       = {tail_wrap_q, tail_q} - {head_wrap_q, head_q};
    assign full       = (head_q == tail_q) & (head_wrap_q != tail_wrap_q);
    assign valid_o    = (head_q != tail_q) | (head_wrap_q != tail_wrap_q);
    assign data_o     = mem_q[head_q];
    assign space_ok_o = (int'(used) <= FIFO_DEPTH - MAC_LATENCY - 1);   // Room for MAC pipe.

    always_ff @(posedge clk) begin
        if (rst) begin
            {head_wrap_q, head_q} <= '0;
            {tail_wrap_q, tail_q} <= '0;
        end else begin
            if (push_i) {tail_wrap_q, tail_q} <= {tail_wrap_q, tail_q} + 1'b1;
            if (pop_i) {head_wrap_q, head_q} <= {head_wrap_q, head_q} + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem_q[tail_q] <= push_data_i;
    end

    // Fetch throttling keeps the MAC from outrunning the writer.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push_i |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop_i |-> valid_o);

endmodule

// File: hw/result_writer.sv
`timescale 1ns/1ps

module result_writer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_conv_i,
    input  logic [cnn_pkg::DATA_W-1:0] dst_addr_i,
    input  logic [cnn_pkg::LEN_W-1:0]  res_count_i,
    input  logic                       fifo_valid_i,
    input  logic [cnn_pkg::DATA_W-1:0] fifo_data_i,
    input  logic                       rd_valid_i,
    input  logic [cnn_pkg::DATA_W-1:0] rd_addr_i,
    input  logic                       mem_ready_i,
    output logic                       fifo_pop_o,
    output logic                       write_done_o,
    output logic                       rd_ready_o,
    output logic                       mem_valid_o,
    output logic [cnn_pkg::DATA_W-1:0] mem_addr_o,
    output logic                       mem_read_o,
    output logic [cnn_pkg::DATA_W-1:0] mem_wdata_o
);
    import cnn_pkg::*;

    logic [DATA_W-1:0] wr_addr_q;
    logic [LEN_W-1:0]  wr_cnt_q;
    logic              wr_lock_q;               // Write shown, still stalled.
    logic              grant_rd;
    logic              wr_sel;

    // Reads win unless a stalled write is already on the port.
    assign grant_rd = rd_valid_i & ~wr_lock_q;
    assign wr_sel   = ~grant_rd & fifo_valid_i;

    assign mem_valid_o = grant_rd | wr_sel;
    assign mem_read_o  = grant_rd;
    assign mem_addr_o  = grant_rd ? rd_addr_i : wr_addr_q;
    assign mem_wdata_o = fifo_data_i;
    assign rd_ready_o  = mem_ready_i & ~wr_lock_q;

    assign fifo_pop_o   = wr_sel & mem_ready_i;
    assign write_done_o = fifo_pop_o & (wr_cnt_q == res_count_i - LEN_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr_q <= '0;
            wr_cnt_q  <= '0;
            wr_lock_q <= 1'b0;
        end else begin
            wr_lock_q <= wr_sel & ~mem_ready_i;
            if (start_conv_i) begin
                wr_addr_q <= dst_addr_i;
                wr_cnt_q  <= '0;
            end else if (fifo_pop_o) begin
                wr_addr_q <= wr_addr_q + DATA_W'(4);
                wr_cnt_q  <= wr_cnt_q + LEN_W'(1);
            end
        end
    end

    // Port request holds under back-pressure.
    a_port_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_valid_o && !mem_ready_i) |=>
            (mem_valid_o && $stable(mem_addr_o) && $stable(mem_read_o)));

endmodule

// File: hw/conv_accel_top.sv
`timescale 1ns/1ps

module conv_accel_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  cnn_pkg::opcode_e           req_op_i,
    input  logic                       req_imm_i,
    input  logic [cnn_pkg::DATA_W-1:0] req_rj_i,
    input  logic [cnn_pkg::DATA_W-1:0] req_rk_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output logic                       mem_valid_o,
    input  logic                       mem_ready_i,
    output logic [cnn_pkg::DATA_W-1:0] mem_addr_o,
    output logic                       mem_read_o,
    output logic [cnn_pkg::DATA_W-1:0] mem_wdata_o,
    input  logic                       mem_rsp_valid_i,
    input  logic [cnn_pkg::DATA_W-1:0] mem_rsp_rdata_i
);
    import cnn_pkg::*;

    logic                 start_weight, start_conv, fetch_done, write_done;
    logic [DATA_W-1:0]    src_addr, weight_addr, dst_addr, rd_addr, res_data, fifo_data;
    logic [LEN_W-1:0]     length, res_count;
    logic [TAP_IDX_W-1:0] taps;
    logic                 rd_valid, rd_ready, win_valid, res_valid;
    logic                 space_ok, fifo_valid, fifo_pop;
    window_t              window;
    weights_t             weights;

    cmd_decoder u_cmd_decoder (
        .clk, .rst, .req_valid_i, .req_op_i, .req_imm_i, .req_rj_i, .req_rk_i,
        .fetch_done_i(fetch_done), .write_done_i(write_done),
        .req_ready_o, .rsp_valid_o,
        .start_weight_o(start_weight), .start_conv_o(start_conv),
        .src_addr_o(src_addr), .weight_addr_o(weight_addr), .dst_addr_o(dst_addr),
        .length_o(length), .taps_o(taps), .res_count_o(res_count)
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    window_fetch u_window_fetch (
        .clk, .rst, .start_weight_i(start_weight), .start_conv_i(start_conv),
        .src_addr_i(src_addr), .weight_addr_i(weight_addr),
        .length_i(length), .taps_i(taps), .rd_ready_i(rd_ready),
        .rsp_valid_i(mem_rsp_valid_i), .rsp_rdata_i(mem_rsp_rdata_i),
        .space_ok_i(space_ok), .rd_valid_o(rd_valid), .rd_addr_o(rd_addr),
        .fetch_done_o(fetch_done), .win_valid_o(win_valid),
        .window_o(window), .weights_o(weights)
    );

    conv_mac u_conv_mac (
        .clk, .rst, .win_valid_i(win_valid), .window_i(window), .weights_i(weights),
        .res_valid_o(res_valid), .res_data_o(res_data)
    );

    result_fifo u_result_fifo (
        .clk, .rst, .push_i(res_valid), .push_data_i(res_data), .pop_i(fifo_pop),
        .valid_o(fifo_valid), .data_o(fifo_data), .space_ok_o(space_ok)
    );

    result_writer u_result_writer (
        .clk, .rst, .start_conv_i(start_conv), .dst_addr_i(dst_addr),
        .res_count_i(res_count), .fifo_valid_i(fifo_valid), .fifo_data_i(fifo_data),
        .rd_valid_i(rd_valid), .rd_addr_i(rd_addr), .mem_ready_i,
        .fifo_pop_o(fifo_pop), .write_done_o(write_done), .rd_ready_o(rd_ready),
        .mem_valid_o, .mem_addr_o, .mem_read_o, .mem_wdata_o
    );

endmodule

// File: bench/tb_conv_accel.sv
`timescale 1ns/1ps

module tb_conv_accel;
    import cnn_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int MEM_WORDS = 256;
    localparam int MAX_N     = 8;

    // ------------------------------
    // Test table
    // ------------------------------
    logic [31:0] src_tab  [NUM_TESTS] = '{32'h100, 32'h140, 32'h180, 32'h1c0, 32'h100};
    logic [31:0] dst_tab  [NUM_TESTS] = '{32'h200, 32'h240, 32'h280, 32'h2c0, 32'h300};
    logic [31:0] wadr_tab [NUM_TESTS] = '{32'h000, 32'h010, 32'h020, 32'h030, 32'h000};
    int          n_tab    [NUM_TESTS] = '{8, 8, 6, 4, 8};
    int          k_tab    [NUM_TESTS] = '{3, 3, 1, 4, 3};
    logic        load_tab [NUM_TESTS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
    logic        busy_tab [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};  // Random ready, latency.
    int          ref_tab  [NUM_TESTS] = '{-1, -1, -1, -1, 0};   // Test with equal results.
    logic [31:0] w_tab    [NUM_TESTS][MAX_TAPS] = '{
        '{32'd3, 32'hffff_fffe, 32'd5, 32'd0},
        '{32'd0, 32'd0, 32'd0, 32'd0},
        '{32'd7, 32'd0, 32'd0, 32'd0},
        '{32'd1, 32'd2, 32'd3, 32'h1000_0000},
        '{32'd3, 32'hffff_fffe, 32'd5, 32'd0}
    };
    logic [31:0] in_tab   [NUM_TESTS][MAX_N] = '{
        '{32'd1, 32'd2, 32'd3, 32'h8000_0001, 32'd10, 32'hffff_ffff, 32'd100, 32'd7},
        '{32'd5, 32'd4, 32'd3, 32'd2, 32'd1, 32'd0, 32'h1234_5678, 32'd9},
        '{32'd11, 32'd22, 32'd33, 32'h2000_0000, 32'd55, 32'd66, 32'd0, 32'd0},
        '{32'h10, 32'h20, 32'h30, 32'h40, 32'd0, 32'd0, 32'd0, 32'd0},
        '{32'd1, 32'd2, 32'd3, 32'h8000_0001, 32'd10, 32'hffff_ffff, 32'd100, 32'd7}
    };

    logic        clk, rst;
    logic        req_valid_i, req_imm_i, req_ready_o, rsp_valid_o;
    opcode_e     req_op_i;
    logic [31:0] req_rj_i, req_rk_i;
    logic        mem_valid_o, mem_ready_i, mem_read_o, mem_rsp_valid_i;
    logic [31:0] mem_addr_o, mem_wdata_o, mem_rsp_rdata_i;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] cur_w [MAX_TAPS];              // Weights held by the DUT.
    logic [31:0] wr_lo, wr_hi, rsp_word;
    logic        busy_mode, in_run;
    int          seed = 32'hea11;
    int          errors, test_errs, passed, wr_count, rsp_wait;
    int          cycles = 0;
    int          cycle_limit;

    conv_accel_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    always begin
        @(negedge clk);
        if (!rst && mem_valid_o && !in_run)
            flag_mismatch($sformatf("port request at 0x%08h outside a run", mem_addr_o));
        if (!rst && mem_valid_o && mem_ready_i) begin
            if (mem_read_o) begin
                rsp_word = mem[mem_addr_o[9:2]];
                rsp_wait = busy_mode ? 1 + ($random(seed) & 3) : 1;
            end else begin
                if (mem_addr_o < wr_lo || mem_addr_o > wr_hi || mem_addr_o[1:0] != 2'b00)
                    flag_mismatch($sformatf("write to 0x%08h outside the results", mem_addr_o));
                else
                    mem[mem_addr_o[9:2]] = mem_wdata_o;
                wr_count++;
            end
        end
        @(posedge clk);
        #1;
        mem_ready_i     = busy_mode ? 1'($random(seed) & 1) : 1'b1;
        mem_rsp_valid_i = 1'b0;
        if (rsp_wait != 0) begin
            rsp_wait--;
            if (rsp_wait == 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_rdata_i = rsp_word;
            end
        end
    end

    task automatic send_cmd(input opcode_e op, input logic imm, input logic [31:0] rj,
                            input logic [31:0] rk);
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_imm_i   = imm;
        req_rj_i    = rj;
        req_rk_i    = rk;
        @(negedge clk);
        while (!req_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic conf_cmd(input opcode_e op, input logic [31:0] rj, input logic [31:0] rk);
        send_cmd(op, 1'b0, rj, rk);
        @(negedge clk);
        if (rsp_valid_o !== 1'b1) flag_mismatch($sformatf("no response to %s", op.name()));
        @(posedge clk);
        #1;
        @(negedge clk);
        if (rsp_valid_o !== 1'b0) flag_mismatch("rsp_valid_o longer than one cycle");
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int t);
        int          n, k, n_res;
        logic [31:0] expv, got;
        n         = n_tab[t];
        k         = k_tab[t];
        n_res     = n - k + 1;
        test_errs = 0;
        for (int i = 0; i < n; i++) mem[(src_tab[t] >> 2) + i] = in_tab[t][i];
        if (load_tab[t]) begin
            for (int i = 0; i < MAX_TAPS; i++) cur_w[i] = (i < k) ? w_tab[t][i] : 32'd0;
            for (int i = 0; i < k; i++) mem[(wadr_tab[t] >> 2) + i] = w_tab[t][i];
        end
        busy_mode = busy_tab[t];
        conf_cmd(OP_CONF_SRC, src_tab[t], {17'd0, 3'(k), 12'(n)});
        conf_cmd(OP_CONF_DST, dst_tab[t], 32'd0);
        wr_lo    = dst_tab[t];
        wr_hi    = dst_tab[t] + 32'(4 * (n_res - 1));
        wr_count = 0;
        in_run   = 1'b1;
        send_cmd(OP_CONV, load_tab[t], wadr_tab[t], 32'd0);
        @(negedge clk);
        while (!rsp_valid_o) begin
            if (req_ready_o) flag_mismatch("req_ready_o high during a run");
            @(negedge clk);
        end
        if (wr_count != n_res)
            flag_mismatch($sformatf("completion after %0d of %0d writes", wr_count, n_res));
        @(posedge clk);
        #1;
        in_run = 1'b0;
        for (int j = 0; j < n_res; j++) begin
            expv = 32'd0;
            for (int i = 0; i < k; i++) expv += in_tab[t][j + i] * cur_w[i];   // Mod 2^32.
            got = mem[(dst_tab[t] >> 2) + j];
            if (got !== expv)
                flag_mismatch($sformatf("result %0d is 0x%08h, expected 0x%08h", j, got, expv));
            if (ref_tab[t] >= 0 && got !== mem[(dst_tab[ref_tab[t]] >> 2) + j])
                flag_mismatch($sformatf("result %0d differs from test %0d", j, ref_tab[t]));
        end
        if (test_errs == 0) begin
            passed++;
            $display("test %0d: N=%0d K=%0d load=%0d ok", t, n, k, load_tab[t]);
        end else begin
            $display("test %0d: N=%0d K=%0d load=%0d %0d errors", t, n, k, load_tab[t], test_errs);
        end
    endtask

    initial begin
        rst             = 1'b1;
        req_valid_i     = 1'b0;
        req_op_i        = OP_NOP;
        req_imm_i       = 1'b0;
        req_rj_i        = '0;
        req_rk_i        = '0;
        mem_ready_i     = 1'b1;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_rdata_i = '0;
        busy_mode       = 1'b0;
        in_run          = 1'b0;
        wr_lo           = '0;
        wr_hi           = '0;
        wr_count        = 0;
        rsp_wait        = 0;
        errors          = 0;
        passed          = 0;
        cycle_limit     = 0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'ha5a5_0000 | 32'(i * 4);
        for (int t = 0; t < NUM_TESTS; t++) cycle_limit += 40 * (n_tab[t] + k_tab[t]) + 50;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0 || mem_valid_o !== 1'b0)
            flag_mismatch("outputs not idle after reset");
        @(posedge clk);
        #1;
        conf_cmd(OP_NOP, 32'd0, 32'd0);
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, passed, NUM_TESTS - passed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/cnn_pkg.sv
hw/cmd_decoder.sv
hw/window_fetch.sv
hw/conv_mac.sv
hw/result_fifo.sv
hw/result_writer.sv
hw/conv_accel_top.sv
bench/tb_conv_accel.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -sv -Wno-fatal \
    --top-module tb_conv_accel -f all.f \
    --Mdir obj_dir -o tb_conv_accel

./obj_dir/tb_conv_accel | tee sim.log

grep -q "TESTBENCH PASSED" sim.log
